// ==== sources.f ====
+incdir+tb
hw/rv32i_pkg.sv
hw/control_unit.sv
hw/reg_file.sv
hw/alu.sv
hw/fetch_unit.sv
hw/load_align.sv
hw/rv32i_core.sv
tb/tb_rv32i_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f sources.f \
  --top-module tb_rv32i_core -o sim_rv32i

./obj_dir/sim_rv32i | tee sim.log

if grep -q "Result: PASSED" sim.log; then
  exit 0
else
  exit 1
fi

// ==== tb/rv32i_ref_model.svh ====
`ifndef RV32I_REF_MODEL_SVH
`define RV32I_REF_MODEL_SVH

// Architectural state of the model
logic [31:0] m_regs [0:31];
logic [31:0] m_mem [0:63];
logic [31:0] m_pc;

// Expected retirement trace, oldest first
logic [4:0]  exp_rd [$];
logic [31:0] exp_val [$];

function automatic logic [31:0] model_alu(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b,
                                          input logic is_reg);
  case (f3)
    3'd0: return (is_reg && alt) ? a - b : a + b;
    3'd1: return a << b[4:0];
    3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3: return (a < b) ? 32'd1 : 32'd0;
    3'd4: return a ^ b;
    3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

task automatic model_step(input logic [31:0] ins);
  logic [4:0]  rd;
  logic [2:0]  f3;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_j;
  logic [31:0] res;
  logic [31:0] addr;
  logic [31:0] word;
  logic [31:0] npc;
  logic        wr;
  logic        tk;
  rd    = ins[11:7];
  f3    = ins[14:12];
  a     = m_regs[ins[19:15]];
  b     = m_regs[ins[24:20]];
  imm_i = {{20{ins[31]}}, ins[31:20]};
  imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
  imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
  imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
  wr    = 1'b1;
  res   = '0;
  npc   = m_pc + 32'd4;
  addr  = a + imm_i;
  word  = m_mem[addr[7:2]];
  case (ins[6:0])
    7'b0110111: res = {ins[31:12], 12'b0};
    7'b0010111: res = m_pc + {ins[31:12], 12'b0};
    7'b1101111: begin
      res = m_pc + 32'd4;
      npc = m_pc + imm_j;
    end
    7'b1100111: begin
      res = m_pc + 32'd4;
      npc = addr & ~32'd1;
    end
    7'b1100011: begin
      wr = 1'b0;
      case (f3)
        3'd0: tk = (a == b);
        3'd1: tk = (a != b);
        3'd4: tk = ($signed(a) < $signed(b));
        3'd5: tk = ($signed(a) >= $signed(b));
        3'd6: tk = (a < b);
        default: tk = (a >= b);
      endcase
      if (tk) begin
        npc = m_pc + imm_b;
      end
    end
    7'b0000011: begin
      case (f3)
        3'd0: res = {{24{word[addr[1:0]*8+7]}}, word[addr[1:0]*8 +: 8]};
        3'd4: res = {24'b0, word[addr[1:0]*8 +: 8]};
        3'd1: res = {{16{word[addr[1]*16+15]}}, word[addr[1]*16 +: 16]};
        3'd5: res = {16'b0, word[addr[1]*16 +: 16]};
        default: res = word;
      endcase
    end
    7'b0100011: begin
      wr   = 1'b0;
      addr = a + imm_s;
      case (f3)
        3'd0: m_mem[addr[7:2]][addr[1:0]*8 +: 8] = b[7:0];
        3'd1: m_mem[addr[7:2]][addr[1]*16 +: 16] = b[15:0];
        default: m_mem[addr[7:2]] = b;
      endcase
    end
    7'b0010011: res = model_alu(f3, ins[30], a, imm_i, 1'b0);
    7'b0110011: res = model_alu(f3, ins[30], a, b, 1'b1);
    default: wr = 1'b0;
  endcase
  if (wr && rd != 5'd0) begin
    m_regs[rd] = res;
    exp_rd.push_back(rd);
    exp_val.push_back(res);
  end
  m_pc = npc;
endtask

`endif

// ==== tb/tb_rv32i_core.sv ====
`default_nettype none

module tb_rv32i_core import rv32i_pkg::*; ();

  localparam int NUM_TESTS    = 4;
  localparam int RESET_CYCLES = 8;
  localparam int HOLD_CYCLES  = 6;
  // Each test runs at most 64 instructions plus reset and the halt hold
  localparam int TIMEOUT = NUM_TESTS * (80 + RESET_CYCLES + HOLD_CYCLES);

  logic        clk;
  logic        rst_n;
  logic [31:0] imem_addr;
  logic [31:0] imem_rdata;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic [3:0]  dmem_byte_en;
  logic        dmem_wen;
  logic        dmem_ren;
  logic [31:0] dmem_rdata;
  logic        rf_wen;
  logic [4:0]  rf_waddr;
  logic [31:0] rf_wdata;
  logic        halt;

  logic [31:0] rom [0:63];
  logic [31:0] ram [0:63];
  logic [31:0] seed;
  int          wp;
  int          errors;
  int          checks;
  int          cycles;

  `include "rv32i_ref_model.svh"

  rv32i_core dut0 (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .imem_addr_o    (imem_addr),
    .imem_rdata_i   (imem_rdata),
    .dmem_addr_o    (dmem_addr),
    .dmem_wdata_o   (dmem_wdata),
    .dmem_byte_en_o (dmem_byte_en),
    .dmem_wen_o     (dmem_wen),
    .dmem_ren_o     (dmem_ren),
    .dmem_rdata_i   (dmem_rdata),
    .rf_wen_o       (rf_wen),
    .rf_waddr_o     (rf_waddr),
    .rf_wdata_o     (rf_wdata),
    .halt_o         (halt)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  assign imem_rdata = rom[imem_addr[7:2]];
  assign dmem_rdata = ram[dmem_addr[7:2]];

  // Byte-enabled RAM write
  always @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (dmem_wen && dmem_byte_en[i]) begin
        ram[dmem_addr[7:2]][i*8 +: 8] <= dmem_wdata[i*8 +: 8];
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("error: timeout after %0d cycles, the core never reached halt", cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  // Retirement and reset gating checks, sampled mid-cycle
  always @(negedge clk) begin
    if (!rst_n) begin
      checks++;
      assert (!dmem_wen && !rf_wen) else begin
        $display("error: write strobe active during reset at %0t", $time);
        errors++;
      end
    end else begin
      checks++;
      assert (dmem_ren == (imem_rdata[6:0] == 7'b0000011)) else begin
        $display("mismatch at %0t: read strobe %b for instruction %h", $time, dmem_ren,
                 imem_rdata);
        errors++;
      end
      if (rf_wen) begin
        checks++;
        if (exp_rd.size() == 0) begin
          $display("error: register write to x%0d at %0t that the model never made",
                   rf_waddr, $time);
          errors++;
        end else begin
          assert (rf_waddr == exp_rd[0] && rf_wdata == exp_val[0]) else begin
            $display("mismatch at %0t: write x%0d=%h, expected x%0d=%h", $time,
                     rf_waddr, rf_wdata, exp_rd[0], exp_val[0]);
            errors++;
          end
          void'(exp_rd.pop_front());
          void'(exp_val.pop_front());
        end
      end
    end
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic int unsigned pick(input int unsigned n);
    logic [31:0] r;
    r = next_rand();
    return (r >> 8) % n;
  endfunction

  function automatic logic [4:0] src_reg();
    return 5'(pick(8) + 1);
  endfunction

  task automatic put(input logic [31:0] ins);
    rom[wp] = ins;
    wp++;
  endtask

  // Seed x1..x8 with LUI and ADDI
  task automatic seed_regs();
    logic [31:0] r;
    for (int i = 1; i <= 8; i++) begin
      r = next_rand();
      put({r[31:12], 5'(i), 7'b0110111});
      put({r[11:0], 5'(i), 3'd0, 5'(i), 7'b0010011});
    end
  endtask

  task automatic gen_alu();
    logic [31:0] r;
    logic [2:0]  f3;
    logic [6:0]  f7;
    seed_regs();
    for (int i = 0; i < 40; i++) begin
      r  = next_rand();
      f3 = r[14:12];
      f7 = (r[30] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'b0100000 : 7'b0;
      if (r[3]) begin
        put({f7, src_reg(), src_reg(), f3, 5'(pick(9)), 7'b0110011});
      end else if (f3 == 3'd1 || f3 == 3'd5) begin
        put({(f3 == 3'd5) ? f7 : 7'b0, r[24:20], src_reg(), f3, 5'(pick(9)), 7'b0010011});
      end else begin
        put({r[31:20], src_reg(), f3, 5'(pick(9)), 7'b0010011});
      end
    end
  endtask

  task automatic gen_mem();
    logic [11:0] off;
    logic [1:0]  size;
    logic        uns;
    // Store of x0 at PC 0, fetched while reset is held
    put({7'd0, 5'd0, 5'd0, 3'd2, 5'd0, 7'b0100011});
    seed_regs();
    for (int i = 0; i < 20; i++) begin
      size = 2'(pick(3));
      uns  = pick(2) == 1 && size != 2'd2;
      off  = 12'(pick(64) * 4);
      if (size == 2'd0) off = off + 12'(pick(4));
      if (size == 2'd1) off = off + 12'(pick(2) * 2);
      put({off[11:5], src_reg(), 5'd0, 1'b0, size, off[4:0], 7'b0100011});
      put({off, 5'd0, uns, size, src_reg(), 7'b0000011});
    end
  endtask

  task automatic gen_ctrl();
    logic [2:0]  kinds [0:5];
    logic [12:0] skip;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    int          k;
    kinds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    seed_regs();
    for (int i = 0; i < 15; i++) begin
      k    = pick(8);
      skip = (pick(2) == 1) ? 13'd12 : 13'd8;
      rs1  = src_reg();
      rs2  = (pick(4) == 0) ? rs1 : src_reg();
      if (k < 6) begin
        put({skip[12], skip[10:5], rs2, rs1, kinds[k], skip[4:1], skip[11], 7'b1100011});
      end else if (k == 6) begin
        put({1'b0, skip[10:1], 1'b0, 8'd0, src_reg(), 7'b1101111});
      end else begin
        put({12'(wp * 4 + skip), 5'd0, 3'd0, src_reg(), 7'b1100111});
      end
      put({12'(pick(4096)), src_reg(), 3'd0, src_reg(), 7'b0010011});
      put({12'(pick(4096)), src_reg(), 3'd0, src_reg(), 7'b0010011});
    end
  endtask

  task automatic gen_upper();
    logic [31:0] r;
    for (int i = 0; i < 40; i++) begin
      r = next_rand();
      put({r[31:12], 5'(pick(9)), r[4] ? 7'b0110111 : 7'b0010111});
    end
  endtask

  task automatic run_test(input int num, input string name);
    logic [31:0] hold_pc;
    int          err0;
    err0 = errors;
    @(posedge clk);
    rst_n <= 1'b0;
    // New images go in while the write strobes are gated off
    @(negedge clk);
    for (int i = 0; i < 64; i++) begin
      rom[i]   = HALT_INSTR;
      m_mem[i] = 32'(i) * 32'h9e3779b1 ^ 32'h5a0f_c3e1;
      ram[i]   <= m_mem[i];
    end
    wp = 0;
    case (num)
      0: gen_alu();
      1: gen_mem();
      2: gen_ctrl();
      default: gen_upper();
    endcase
    m_pc = '0;
    while (rom[m_pc[7:2]] != HALT_INSTR) begin
      model_step(rom[m_pc[7:2]]);
    end
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    while (!halt) begin
      @(negedge clk);
    end
    checks++;
    assert (exp_rd.size() == 0 && imem_addr == m_pc) else begin
      $display("error: halted at %h with %0d expected writes missing, model halt at %h",
               imem_addr, exp_rd.size(), m_pc);
      errors++;
    end
    hold_pc = imem_addr;
    repeat (HOLD_CYCLES) begin
      @(negedge clk);
      checks++;
      assert (halt && !dmem_wen && imem_addr == hold_pc) else begin
        $display("error: core left the halt state at %0t", $time);
        errors++;
      end
    end
    for (int i = 0; i < 64; i++) begin
      checks++;
      assert (ram[i] == m_mem[i]) else begin
        $display("mismatch at %0t: ram word %0d is %h, expected %h", $time, i,
                 ram[i], m_mem[i]);
        errors++;
      end
    end
    exp_rd.delete();
    exp_val.delete();
    $display("test %0d %s: %s (%0d errors)", num, name,
             (errors == err0) ? "ok" : "bad", errors - err0);
  endtask

  initial begin
    rst_n  <= 1'b0;
    seed   = 32'h9508149c;
    errors = 0;
    checks = 0;
    cycles = 0;
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
    end
    run_test(0, "alu");
    run_test(1, "load/store");
    run_test(2, "control flow");
    run_test(3, "auipc/lui");
    $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/rv32i_core.sv ====
`default_nettype none

module rv32i_core import rv32i_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_n_i,
  output logic [XLEN-1:0] imem_addr_o,
  input  logic [XLEN-1:0] imem_rdata_i,
  output logic [XLEN-1:0] dmem_addr_o,
  output logic [XLEN-1:0] dmem_wdata_o,
  output logic [3:0]      dmem_byte_en_o,
  output logic            dmem_wen_o,
  output logic            dmem_ren_o,
  input  logic [XLEN-1:0] dmem_rdata_i,
  output logic            rf_wen_o,
  output logic [4:0]      rf_waddr_o,
  output logic [XLEN-1:0] rf_wdata_o,
  output logic            halt_o
);

  ctrl_t           ctrl;
  logic [3:0]      byte_en;
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] pc_plus4;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic [XLEN-1:0] alu_a;
  logic [XLEN-1:0] alu_b;
  logic [XLEN-1:0] alu_result;
  logic [XLEN-1:0] load_data;
  logic [XLEN-1:0] wb_data;
  logic [XLEN-1:0] store_data;
  logic            rf_wen;

  control_unit u_control_unit (
    .instr_i       (imem_rdata_i),
    .byte_offset_i (alu_result[1:0]),
    .ctrl_o        (ctrl),
    .byte_en_o     (byte_en)
  );

  reg_file u_reg_file (
    .clk_i      (clk_i),
    .rs1_i      (ctrl.rs1),
    .rs2_i      (ctrl.rs2),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .wen_i      (rf_wen),
    .rd_i       (ctrl.rd),
    .wdata_i    (wb_data)
  );

  // Operand muxes
  assign alu_a = (ctrl.alu_a_sel == ASEL_PC) ? pc : rs1_data;
  assign alu_b = (ctrl.alu_b_sel == BSEL_IMM) ? ctrl.imm : rs2_data;

  alu u_alu (
    .op_i     (ctrl.alu_op),
    .a_i      (alu_a),
    .b_i      (alu_b),
    .result_o (alu_result)
  );

  fetch_unit u_fetch_unit (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .ctrl_i       (ctrl),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .alu_result_i (alu_result),
    .pc_o         (pc),
    .halt_o       (halt_o)
  );

  load_align u_load_align (
    .load_type_i   (ctrl.load_type),
    .byte_offset_i (alu_result[1:0]),
    .rdata_i       (dmem_rdata_i),
    .data_o        (load_data)
  );

  assign pc_plus4 = pc + 32'd4;

  always_comb begin
    case (ctrl.w_sel)
      WSEL_LOAD: wb_data = load_data;
      WSEL_PC4:  wb_data = pc_plus4;
      WSEL_IMM:  wb_data = ctrl.imm;
      default:   wb_data = alu_result;
    endcase
  end

  // Store data moved into the addressed byte lanes
  always_comb begin
    case (ctrl.load_type)
      LB:      store_data = {24'b0, rs2_data[7:0]} << {alu_result[1:0], 3'b000};
      LH:      store_data = {16'b0, rs2_data[15:0]} << {alu_result[1], 4'b0000};
      default: store_data = rs2_data;
    endcase
  end

  // No writes of any kind while in reset
  assign rf_wen = rst_n_i && ctrl.wen && (ctrl.rd != 5'd0);

  assign imem_addr_o    = pc;
  assign dmem_addr_o    = {alu_result[XLEN-1:2], 2'b00};
  assign dmem_wdata_o   = store_data;
  assign dmem_byte_en_o = byte_en;
  assign dmem_wen_o     = rst_n_i && ctrl.dwen;
  assign dmem_ren_o     = rst_n_i && ctrl.dren;
  assign rf_wen_o       = rf_wen;
  assign rf_waddr_o     = ctrl.rd;
  assign rf_wdata_o     = wb_data;

endmodule

`default_nettype wire

// ==== hw/load_align.sv ====
`default_nettype none

module load_align import rv32i_pkg::*; (
  input  load_t           load_type_i,
  input  logic [1:0]      byte_offset_i,
  input  logic [XLEN-1:0] rdata_i,
  output logic [XLEN-1:0] data_o
);

  logic [7:0]  byte_sel;
  logic [15:0] half_sel;

  // Addressed byte and halfword of the word
  assign byte_sel = rdata_i[{byte_offset_i, 3'b000} +: 8];
  assign half_sel = byte_offset_i[1] ? rdata_i[31:16] : rdata_i[15:0];

  always_comb begin
    case (load_type_i)
      LB:      data_o = {{24{byte_sel[7]}}, byte_sel};
      LBU:     data_o = {24'b0, byte_sel};
      LH:      data_o = {{16{half_sel[15]}}, half_sel};
      LHU:     data_o = {16'b0, half_sel};
      LW:      data_o = rdata_i;
      default: data_o = rdata_i;
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/fetch_unit.sv ====
`default_nettype none

module fetch_unit import rv32i_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  ctrl_t           ctrl_i,
  input  logic [XLEN-1:0] rs1_data_i,
  input  logic [XLEN-1:0] rs2_data_i,
  input  logic [XLEN-1:0] alu_result_i,
  output logic [XLEN-1:0] pc_o,
  output logic            halt_o
);

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] pc_next;
  logic            cond;
  logic            taken;

  // Branch condition from funct3
  always_comb begin
    case (ctrl_i.branch_type)
      BEQ:     cond = (rs1_data_i == rs2_data_i);
      BNE:     cond = (rs1_data_i != rs2_data_i);
      BLT:     cond = ($signed(rs1_data_i) < $signed(rs2_data_i));
      BGE:     cond = ($signed(rs1_data_i) >= $signed(rs2_data_i));
      BLTU:    cond = (rs1_data_i < rs2_data_i);
      BGEU:    cond = (rs1_data_i >= rs2_data_i);
      default: cond = 1'b0;
    endcase
  end

  assign taken = ctrl_i.branch && cond;

  always_comb begin
    if (ctrl_i.halt) begin
      pc_next = pc_q;
    end else if (ctrl_i.jump && !ctrl_i.j_sel) begin
      // JALR clears bit 0 of the target
      pc_next = {alu_result_i[XLEN-1:1], 1'b0};
    end else if (taken || (ctrl_i.jump && ctrl_i.j_sel)) begin
      pc_next = pc_q + ctrl_i.imm;
    end else begin
      pc_next = pc_q + 32'd4;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pc_q <= '0;
    end else begin
      pc_q <= pc_next;
    end
  end

  assign pc_o   = pc_q;
  assign halt_o = ctrl_i.halt;

endmodule

`default_nettype wire

// ==== hw/alu.sv ====
`default_nettype none

module alu import rv32i_pkg::*; (
  input  alu_op_t         op_i,
  input  logic [XLEN-1:0] a_i,
  input  logic [XLEN-1:0] b_i,
  output logic [XLEN-1:0] result_o
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // Shift amount from the low bits of B
  assign shamt = b_i[4:0];

  assign lt_signed   = ($signed(a_i) < $signed(b_i));
  assign lt_unsigned = (a_i < b_i);

  always_comb begin
    case (op_i)
      ALU_ADD:  result_o = a_i + b_i;
      ALU_SUB:  result_o = a_i - b_i;
      ALU_SLL:  result_o = a_i << shamt;
      ALU_SRL:  result_o = a_i >> shamt;
      ALU_SRA:  result_o = $unsigned($signed(a_i) >>> shamt);
      ALU_AND:  result_o = a_i & b_i;
      ALU_OR:   result_o = a_i | b_i;
      ALU_XOR:  result_o = a_i ^ b_i;
      ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
      default:  result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/reg_file.sv ====
`default_nettype none

module reg_file import rv32i_pkg::*; (
  input  logic            clk_i,
  input  logic [4:0]      rs1_i,
  input  logic [4:0]      rs2_i,
  output logic [XLEN-1:0] rs1_data_o,
  output logic [XLEN-1:0] rs2_data_o,
  input  logic            wen_i,
  input  logic [4:0]      rd_i,
  input  logic [XLEN-1:0] wdata_i
);

  // x0 has no storage
  logic [XLEN-1:0] regs_q [1:31];

  always_ff @(posedge clk_i) begin
    if (wen_i && rd_i != 5'd0) begin
      regs_q[rd_i] <= wdata_i;
    end
  end

  // Combinational reads, x0 reads as zero
  always_comb begin
    rs1_data_o = '0;
    if (rs1_i != 5'd0) begin
      rs1_data_o = regs_q[rs1_i];
    end
  end

  always_comb begin
    rs2_data_o = '0;
    if (rs2_i != 5'd0) begin
      rs2_data_o = regs_q[rs2_i];
    end
  end

endmodule

`default_nettype wire

// ==== hw/control_unit.sv ====
`default_nettype none

module control_unit import rv32i_pkg::*; (
  input  logic [XLEN-1:0] instr_i,
  input  logic [1:0]      byte_offset_i,
  output ctrl_t           ctrl_o,
  output logic [3:0]      byte_en_o
);

  rtype_t          r_fmt;
  itype_t          i_fmt;
  stype_t          s_fmt;
  sbtype_t         sb_fmt;
  utype_t          u_fmt;
  ujtype_t         uj_fmt;
  opcode_t         opcode;
  logic            alt_op;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_sb;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_uj;
  alu_op_t         reg_op;
  alu_op_t         imm_op;

  assign r_fmt  = rtype_t'(instr_i);
  assign i_fmt  = itype_t'(instr_i);
  assign s_fmt  = stype_t'(instr_i);
  assign sb_fmt = sbtype_t'(instr_i);
  assign u_fmt  = utype_t'(instr_i);
  assign uj_fmt = ujtype_t'(instr_i);

  assign opcode = r_fmt.opcode;

  // Bit 30 picks SUB and SRA/SRAI
  assign alt_op = r_fmt.funct7[5];

  // Sign-extended immediates for every format
  assign imm_i  = {{20{i_fmt.imm11_00[11]}}, i_fmt.imm11_00};
  assign imm_s  = {{20{s_fmt.imm11_05[6]}}, s_fmt.imm11_05, s_fmt.imm04_00};
  assign imm_sb = {{19{sb_fmt.imm12}}, sb_fmt.imm12, sb_fmt.imm11,
                   sb_fmt.imm10_05, sb_fmt.imm04_01, 1'b0};
  assign imm_u  = {u_fmt.imm31_12, 12'b0};
  assign imm_uj = {{11{uj_fmt.imm20}}, uj_fmt.imm20, uj_fmt.imm19_12,
                   uj_fmt.imm11, uj_fmt.imm10_01, 1'b0};

  // Register-register ALU operation
  always_comb begin
    case (reg_funct3_t'(r_fmt.funct3))
      ADDSUB:  reg_op = alt_op ? ALU_SUB : ALU_ADD;
      SLL:     reg_op = ALU_SLL;
      SLT:     reg_op = ALU_SLT;
      SLTU:    reg_op = ALU_SLTU;
      XOR:     reg_op = ALU_XOR;
      SR:      reg_op = alt_op ? ALU_SRA : ALU_SRL;
      OR:      reg_op = ALU_OR;
      AND:     reg_op = ALU_AND;
      default: reg_op = ALU_ADD;
    endcase
  end

  // Register-immediate ALU operation
  always_comb begin
    case (imm_funct3_t'(i_fmt.funct3))
      ADDI:    imm_op = ALU_ADD;
      SLLI:    imm_op = ALU_SLL;
      SLTI:    imm_op = ALU_SLT;
      SLTIU:   imm_op = ALU_SLTU;
      XORI:    imm_op = ALU_XOR;
      SRI:     imm_op = alt_op ? ALU_SRA : ALU_SRL;
      ORI:     imm_op = ALU_OR;
      ANDI:    imm_op = ALU_AND;
      default: imm_op = ALU_ADD;
    endcase
  end

  always_comb begin
    ctrl_o             = '0;
    ctrl_o.rs1         = r_fmt.rs1;
    ctrl_o.rs2         = r_fmt.rs2;
    ctrl_o.rd          = r_fmt.rd;
    ctrl_o.branch_type = branch_t'(sb_fmt.funct3);
    ctrl_o.load_type   = load_t'(i_fmt.funct3);
    ctrl_o.alu_a_sel   = ASEL_RS1;
    ctrl_o.alu_b_sel   = BSEL_IMM;
    ctrl_o.w_sel       = WSEL_ALU;
    ctrl_o.alu_op      = ALU_ADD;
    ctrl_o.halt        = (instr_i == HALT_INSTR);
    case (opcode)
      LUI: begin
        ctrl_o.imm   = imm_u;
        ctrl_o.wen   = 1'b1;
        ctrl_o.w_sel = WSEL_IMM;
      end
      AUIPC: begin
        ctrl_o.imm       = imm_u;
        ctrl_o.wen       = 1'b1;
        ctrl_o.alu_a_sel = ASEL_PC;
      end
      JAL: begin
        ctrl_o.imm   = imm_uj;
        ctrl_o.wen   = 1'b1;
        ctrl_o.jump  = 1'b1;
        ctrl_o.j_sel = 1'b1;
        ctrl_o.w_sel = WSEL_PC4;
      end
      JALR: begin
        // Target is rs1 + imm through the ALU
        ctrl_o.imm   = imm_i;
        ctrl_o.wen   = 1'b1;
        ctrl_o.jump  = 1'b1;
        ctrl_o.w_sel = WSEL_PC4;
      end
      BRANCH: begin
        ctrl_o.imm    = imm_sb;
        ctrl_o.branch = 1'b1;
      end
      LOAD: begin
        ctrl_o.imm   = imm_i;
        ctrl_o.wen   = 1'b1;
        ctrl_o.dren  = 1'b1;
        ctrl_o.w_sel = WSEL_LOAD;
      end
      STORE: begin
        ctrl_o.imm  = imm_s;
        ctrl_o.dwen = 1'b1;
      end
      IMMED: begin
        ctrl_o.imm    = imm_i;
        ctrl_o.wen    = 1'b1;
        ctrl_o.alu_op = imm_op;
      end
      REGREG: begin
        ctrl_o.wen       = 1'b1;
        ctrl_o.alu_b_sel = BSEL_RS2;
        ctrl_o.alu_op    = reg_op;
      end
      default: begin
        // Unknown opcodes and the halt word do nothing
        ctrl_o.wen = 1'b0;
      end
    endcase
  end

  // Byte lanes for loads and stores, zero when misaligned
  always_comb begin
    byte_en_o = 4'b0000;
    if (ctrl_o.dren || ctrl_o.dwen) begin
      case (ctrl_o.load_type)
        LB, LBU: byte_en_o = 4'b0001 << byte_offset_i;
        LH, LHU: begin
          if (!byte_offset_i[0]) begin
            byte_en_o = 4'b0011 << byte_offset_i;
          end
        end
        LW: begin
          if (byte_offset_i == 2'b00) begin
            byte_en_o = 4'b1111;
          end
        end
        default: byte_en_o = 4'b0000;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/rv32i_pkg.sv ====
`default_nettype none

package rv32i_pkg;

  localparam int XLEN = 32;

  // Fixed encoding that freezes the core
  localparam logic [XLEN-1:0] HALT_INSTR = 32'h7800d073;

  // Operand and write-back select encodings
  localparam logic [1:0] ASEL_RS1  = 2'd0;
  localparam logic [1:0] ASEL_PC   = 2'd1;
  localparam logic [1:0] BSEL_RS2  = 2'd0;
  localparam logic [1:0] BSEL_IMM  = 2'd1;
  localparam logic [1:0] WSEL_LOAD = 2'd0;
  localparam logic [1:0] WSEL_PC4  = 2'd1;
  localparam logic [1:0] WSEL_IMM  = 2'd2;
  localparam logic [1:0] WSEL_ALU  = 2'd3;

  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    IMMED  = 7'b0010011,
    REGREG = 7'b0110011
  } opcode_t;

  // Stores share the size encoding of LB, LH and LW
  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LBU = 3'b100,
    LHU = 3'b101
  } load_t;

  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_t;

  typedef enum logic [2:0] {
    ADDI  = 3'b000,
    SLLI  = 3'b001,
    SLTI  = 3'b010,
    SLTIU = 3'b011,
    XORI  = 3'b100,
    SRI   = 3'b101,
    ORI   = 3'b110,
    ANDI  = 3'b111
  } imm_funct3_t;

  typedef enum logic [2:0] {
    ADDSUB = 3'b000,
    SLL    = 3'b001,
    SLT    = 3'b010,
    SLTU   = 3'b011,
    XOR    = 3'b100,
    SR     = 3'b101,
    OR     = 3'b110,
    AND    = 3'b111
  } reg_funct3_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU
  } alu_op_t;

  // Instruction format views, MSB first
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_t    opcode;
  } rtype_t;

  typedef struct packed {
    logic [11:0] imm11_00;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_t     opcode;
  } itype_t;

  typedef struct packed {
    logic [6:0] imm11_05;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm04_00;
    opcode_t    opcode;
  } stype_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_05;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm04_01;
    logic       imm11;
    opcode_t    opcode;
  } sbtype_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    opcode_t     opcode;
  } utype_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_01;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    opcode_t    opcode;
  } ujtype_t;

  // Decoded control for one instruction
  typedef struct packed {
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [XLEN-1:0] imm;
    logic [1:0]      alu_a_sel;
    logic [1:0]      alu_b_sel;
    logic [1:0]      w_sel;
    logic            wen;
    logic            dren;
    logic            dwen;
    logic            branch;
    logic            jump;
    logic            j_sel;
    branch_t         branch_type;
    load_t           load_type;
    alu_op_t         alu_op;
    logic            halt;
  } ctrl_t;

endpackage

`default_nettype wire
